// ==== source/sump_pkg.sv ====
// ======================================================================
// Shared constants for the SUMP host link
// UART bit timing, command framing widths, the opcode set and the
// reset values of the capture configuration registers
// Modules pull these in with a wildcard import in their body
// ======================================================================

package sump_pkg;

  // Clock cycles per UART bit
  localparam int CLK_PER_BIT = 10;
  localparam int DATA_BITS   = 8;
  localparam int CMD_WORDS   = 5;
  localparam int CMD_WIDTH   = DATA_BITS * CMD_WORDS;

  // Counter widths derived from the framing constants
  localparam int SMPL_CNT_W = $clog2(CLK_PER_BIT + 1);
  localparam int BIT_CNT_W  = $clog2(DATA_BITS);
  localparam int WORD_CNT_W = $clog2(CMD_WORDS + 1);

  typedef enum logic [7:0] {
    OP_RESET      = 8'h00,
    OP_RUN        = 8'h01,
    OP_ID         = 8'h02,
    OP_META       = 8'h04,
    OP_DIVIDER    = 8'h80,
    OP_COUNTS     = 8'h81,
    OP_FLAGS      = 8'h82,
    OP_TRIG_MASK  = 8'hC0,
    OP_TRIG_VALUE = 8'hC1
  } sump_op_t;

  // Identification reply, first byte to send sits in the top byte
  localparam logic [31:0] ID_BYTES = "1ALS";

  localparam logic [23:0] DIVIDER_RESET = 24'h000000;
  localparam logic [7:0]  FLAGS_RESET   = 8'h00;

endpackage

// ==== source/tuart_rx.sv ====
// ======================================================================
// Oversampling UART receiver for SUMP commands
// Takes the synchronized serial line, samples each bit at mid-bit and
// gathers bytes until a short (1 byte) or long (5 byte) command is
// complete, then pulses cmd_rdy_o for one cycle during the stop bit
// ======================================================================

`timescale 1ns/1ps

module tuart_rx (
  input  logic                           clk_i,
  input  logic                           rst_in,
  input  logic                           rx_sync_i,
  output logic [sump_pkg::CMD_WIDTH-1:0] cmd_data_o,
  output logic                           cmd_long_o,
  output logic                           cmd_rdy_o
);

  import sump_pkg::*;

  typedef enum logic [2:0] {IDLE, TRIG, SAMPLE, STOP, STOP2} rx_state_t;

  rx_state_t state;
  rx_state_t state_next;

  logic [SMPL_CNT_W-1:0] smpl_cnt;
  logic [SMPL_CNT_W-1:0] smpl_cnt_next;
  logic [SMPL_CNT_W-1:0] smpl_cnt_cmp;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt_next;
  logic [WORD_CNT_W-1:0] word_cnt;
  logic [WORD_CNT_W-1:0] word_cnt_next;
  logic [CMD_WIDTH-1:0]  shft_data;
  logic [CMD_WIDTH-1:0]  shft_data_next;

  logic take_smpl;
  logic short_ready;
  logic long_ready;

  // Half a bit after the start edge, then one full bit per sample
  assign smpl_cnt_cmp = (state == TRIG) ? SMPL_CNT_W'(CLK_PER_BIT / 2)
                                        : SMPL_CNT_W'(CLK_PER_BIT);
  assign take_smpl    = (smpl_cnt == smpl_cnt_cmp - 1'b1);

  // Bits enter from the top, so the first byte ends up lowest
  assign cmd_data_o = shft_data;

  // Opcode MSB clear after the first byte marks a short command
  assign short_ready = (word_cnt == WORD_CNT_W'(1)) && !shft_data[CMD_WIDTH-1];
  assign long_ready  = (word_cnt == WORD_CNT_W'(CMD_WORDS));
  assign cmd_long_o  = long_ready;

  always_comb begin
    state_next     = state;
    smpl_cnt_next  = smpl_cnt;
    bit_cnt_next   = bit_cnt;
    word_cnt_next  = word_cnt;
    shft_data_next = shft_data;
    cmd_rdy_o      = 1'b0;

    case (state)
      IDLE: begin
        // Falling edge on an idle-high line is a start bit
        if (!rx_sync_i) begin
          state_next    = TRIG;
          smpl_cnt_next = '0;
          if (word_cnt == '0) begin
            shft_data_next = '0;
          end
        end
      end

      TRIG: begin
        smpl_cnt_next = smpl_cnt + 1'b1;
        if (take_smpl) begin
          state_next    = SAMPLE;
          smpl_cnt_next = '0;
          bit_cnt_next  = '0;
        end
      end

      SAMPLE: begin
        smpl_cnt_next = smpl_cnt + 1'b1;
        if (take_smpl) begin
          smpl_cnt_next  = '0;
          bit_cnt_next   = bit_cnt + 1'b1;
          shft_data_next = {rx_sync_i, shft_data[CMD_WIDTH-1:1]};
          if (bit_cnt == BIT_CNT_W'(DATA_BITS - 1)) begin
            state_next    = STOP;
            word_cnt_next = word_cnt + 1'b1;
          end
        end
      end

      STOP: begin
        smpl_cnt_next = smpl_cnt + 1'b1;
        // Report the command at the middle of the stop bit
        if (take_smpl) begin
          state_next    = STOP2;
          smpl_cnt_next = '0;
          if (short_ready || long_ready) begin
            word_cnt_next = '0;
            cmd_rdy_o     = 1'b1;
          end
        end
      end

      STOP2: begin
        if (rx_sync_i) begin
          state_next = IDLE;
        end
      end

      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state    <= IDLE;
      smpl_cnt <= '0;
      bit_cnt  <= '0;
      word_cnt <= '0;
    end else begin
      state    <= state_next;
      smpl_cnt <= smpl_cnt_next;
      bit_cnt  <= bit_cnt_next;
      word_cnt <= word_cnt_next;
    end
  end

  always_ff @(posedge clk_i) begin
    shft_data <= shft_data_next;
  end

endmodule

// ==== source/tuart_tx.sv ====
// ======================================================================
// UART transmitter, one byte per four-phase request
// Sends start bit, eight data bits LSB first and a stop bit, then
// holds tx_ack_o high until the requester drops tx_req_i
// ======================================================================

`timescale 1ns/1ps

module tuart_tx (
  input  logic       clk_i,
  input  logic       rst_in,
  input  logic       tx_req_i,
  input  logic [7:0] tx_data_i,
  output logic       tx_ack_o,
  output logic       tx_o
);

  import sump_pkg::*;

  typedef enum logic [2:0] {IDLE, START, DATA, STOP, ACK} tx_state_t;

  tx_state_t state;

  logic [SMPL_CNT_W-1:0] cyc_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [7:0]            shft;
  logic                  bit_end;
  logic                  load;
  logic                  shift;

  assign bit_end = (cyc_cnt == SMPL_CNT_W'(CLK_PER_BIT - 1));
  assign load    = (state == IDLE) && tx_req_i;
  assign shift   = bit_end && ((state == START) || (state == DATA));

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state    <= IDLE;
      tx_o     <= 1'b1;
      tx_ack_o <= 1'b0;
      cyc_cnt  <= '0;
      bit_cnt  <= '0;
    end else begin
      cyc_cnt <= bit_end ? '0 : cyc_cnt + 1'b1;
      case (state)
        IDLE: begin
          cyc_cnt <= '0;
          if (tx_req_i) begin
            state <= START;
            tx_o  <= 1'b0;
          end
        end
        START: begin
          if (bit_end) begin
            state   <= DATA;
            tx_o    <= shft[0];
            bit_cnt <= '0;
          end
        end
        DATA: begin
          if (bit_end) begin
            if (bit_cnt == BIT_CNT_W'(DATA_BITS - 1)) begin
              state <= STOP;
              tx_o  <= 1'b1;
            end else begin
              tx_o    <= shft[0];
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        STOP: begin
          if (bit_end) begin
            state    <= ACK;
            tx_ack_o <= 1'b1;
          end
        end
        ACK: begin
          cyc_cnt <= '0;
          if (!tx_req_i) begin
            state    <= IDLE;
            tx_ack_o <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Data shifter, next bit always in position 0
  always_ff @(posedge clk_i) begin
    if (load) begin
      shft <= tx_data_i;
    end else if (shift) begin
      shft <= {1'b0, shft[7:1]};
    end
  end

endmodule

// ==== source/sump_cmd_decoder.sv ====
// ======================================================================
// SUMP command decoder
// Long commands load the capture configuration registers, short
// commands reset them, pulse arm_o, or request the ID reply over a
// four-phase id_req/id_ack link. Outputs change one cycle after
// cmd_rdy_i
// ======================================================================

`timescale 1ns/1ps

module sump_cmd_decoder (
  input  logic                           clk_i,
  input  logic                           rst_in,
  input  logic [sump_pkg::CMD_WIDTH-1:0] cmd_data_i,
  input  logic                           cmd_long_i,
  input  logic                           cmd_rdy_i,
  input  logic                           id_ack_i,
  output logic                           id_req_o,
  output logic                           arm_o,
  output logic [31:0]                    trig_mask_o,
  output logic [31:0]                    trig_value_o,
  output logic [23:0]                    divider_o,
  output logic [15:0]                    read_count_o,
  output logic [15:0]                    delay_count_o,
  output logic [7:0]                     flags_o
);

  import sump_pkg::*;

  sump_op_t    op;
  logic [31:0] arg;

  // Short commands arrive in the top byte, long ones in the bottom byte
  assign op  = sump_op_t'(cmd_long_i ? cmd_data_i[7:0]
                                     : cmd_data_i[CMD_WIDTH-1 -: 8]);
  assign arg = cmd_data_i[CMD_WIDTH-1:8];

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      trig_mask_o   <= '0;
      trig_value_o  <= '0;
      divider_o     <= DIVIDER_RESET;
      read_count_o  <= '0;
      delay_count_o <= '0;
      flags_o       <= FLAGS_RESET;
      arm_o         <= 1'b0;
    end else begin
      arm_o <= 1'b0;
      if (cmd_rdy_i) begin
        case (op)
          OP_RESET: begin
            trig_mask_o   <= '0;
            trig_value_o  <= '0;
            divider_o     <= DIVIDER_RESET;
            read_count_o  <= '0;
            delay_count_o <= '0;
            flags_o       <= FLAGS_RESET;
          end
          OP_RUN:        arm_o        <= 1'b1;
          OP_TRIG_MASK:  trig_mask_o  <= arg;
          OP_TRIG_VALUE: trig_value_o <= arg;
          OP_DIVIDER:    divider_o    <= arg[23:0];
          OP_COUNTS: begin
            read_count_o  <= arg[15:0];
            delay_count_o <= arg[31:16];
          end
          OP_FLAGS:      flags_o      <= arg[7:0];
          // Metadata and unknown opcodes leave everything as is
          default: ;
        endcase
      end
    end
  end

  // ID request held until the responder acknowledges
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      id_req_o <= 1'b0;
    end else if (id_req_o && id_ack_i) begin
      id_req_o <= 1'b0;
    end else if (cmd_rdy_i && (op == OP_ID) && !id_req_o && !id_ack_i) begin
      id_req_o <= 1'b1;
    end
  end

endmodule

// ==== source/sump_id_responder.sv ====
// ======================================================================
// Identification responder
// On id_req_i sends the four ID bytes one by one to the transmitter,
// each as a full four-phase exchange, then acknowledges the request
// ======================================================================

`timescale 1ns/1ps

module sump_id_responder (
  input  logic       clk_i,
  input  logic       rst_in,
  input  logic       id_req_i,
  output logic       id_ack_o,
  input  logic       tx_ack_i,
  output logic       tx_req_o,
  output logic [7:0] tx_data_o
);

  import sump_pkg::*;

  typedef enum logic [1:0] {IDLE, SEND, WAIT_LOW, DONE} id_state_t;

  id_state_t  state;
  logic [1:0] idx;

  // Index 0 picks the top byte of the reply
  assign tx_data_o = ID_BYTES[8 * (3 - idx) +: 8];

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state    <= IDLE;
      idx      <= '0;
      tx_req_o <= 1'b0;
      id_ack_o <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (id_req_i) begin
            state    <= SEND;
            idx      <= '0;
            tx_req_o <= 1'b1;
          end
        end
        SEND: begin
          if (tx_ack_i) begin
            state    <= WAIT_LOW;
            tx_req_o <= 1'b0;
          end
        end
        WAIT_LOW: begin
          // Transmitter must drop its ack before the next byte
          if (!tx_ack_i) begin
            if (idx == 2'd3) begin
              state    <= DONE;
              id_ack_o <= 1'b1;
            end else begin
              state    <= SEND;
              idx      <= idx + 1'b1;
              tx_req_o <= 1'b1;
            end
          end
        end
        DONE: begin
          if (!id_req_i) begin
            state    <= IDLE;
            id_ack_o <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// ==== source/sump_uart_top.sv ====
// ======================================================================
// SUMP host link top level
// Synchronizes the serial input and connects receiver, command
// decoder, ID responder and transmitter
// ======================================================================

`timescale 1ns/1ps

module sump_uart_top (
  input  logic        clk_i,
  input  logic        rst_in,
  input  logic        rx_i,
  output logic        tx_o,
  output logic        arm_o,
  output logic [31:0] trig_mask_o,
  output logic [31:0] trig_value_o,
  output logic [23:0] divider_o,
  output logic [15:0] read_count_o,
  output logic [15:0] delay_count_o,
  output logic [7:0]  flags_o
);

  import sump_pkg::*;

  logic                 rx_meta;
  logic                 rx_sync;
  logic [CMD_WIDTH-1:0] cmd_data;
  logic                 cmd_long;
  logic                 cmd_rdy;
  logic                 id_req;
  logic                 id_ack;
  logic                 tx_req;
  logic [7:0]           tx_data;
  logic                 tx_ack;

  // Two-flop synchronizer, resets to the idle line level
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
    end
  end

  tuart_rx u_rx (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .rx_sync_i  (rx_sync),
    .cmd_data_o (cmd_data),
    .cmd_long_o (cmd_long),
    .cmd_rdy_o  (cmd_rdy)
  );

  sump_cmd_decoder u_decoder (
    .clk_i         (clk_i),
    .rst_in        (rst_in),
    .cmd_data_i    (cmd_data),
    .cmd_long_i    (cmd_long),
    .cmd_rdy_i     (cmd_rdy),
    .id_ack_i      (id_ack),
    .id_req_o      (id_req),
    .arm_o         (arm_o),
    .trig_mask_o   (trig_mask_o),
    .trig_value_o  (trig_value_o),
    .divider_o     (divider_o),
    .read_count_o  (read_count_o),
    .delay_count_o (delay_count_o),
    .flags_o       (flags_o)
  );

  sump_id_responder u_id (
    .clk_i     (clk_i),
    .rst_in    (rst_in),
    .id_req_i  (id_req),
    .id_ack_o  (id_ack),
    .tx_ack_i  (tx_ack),
    .tx_req_o  (tx_req),
    .tx_data_o (tx_data)
  );

  tuart_tx u_tx (
    .clk_i     (clk_i),
    .rst_in    (rst_in),
    .tx_req_i  (tx_req),
    .tx_data_i (tx_data),
    .tx_ack_o  (tx_ack),
    .tx_o      (tx_o)
  );

endmodule

// ==== testbench/sump_uart_chk.sv ====
// ======================================================================
// Concurrent assertions on the internal handshakes of the SUMP host
// link, attached to the top level by the bind statement at the end
// ======================================================================

`timescale 1ns/1ps

module sump_uart_chk (
  input logic       clk_i,
  input logic       rst_in,
  input logic       id_req_i,
  input logic       id_ack_i,
  input logic       tx_req_i,
  input logic       tx_ack_i,
  input logic [7:0] tx_data_i,
  input logic       arm_i,
  input logic       tx_i
);

  int unsigned id_fails   = 0;
  int unsigned data_fails = 0;
  int unsigned arm_fails  = 0;
  int unsigned idle_fails = 0;
  int unsigned fail_total;

  assign fail_total = id_fails + data_fails + arm_fails + idle_fails;

  // Decoder may drop its request only after the responder acknowledged
  id_handshake: assert property (@(posedge clk_i) disable iff (!rst_in)
    $fell(id_req_i) |-> $past(id_ack_i))
    else begin
      $error("id_req fell before id_ack was high");
      id_fails++;
    end

  tx_data_hold: assert property (@(posedge clk_i) disable iff (!rst_in)
    (tx_req_i && $past(tx_req_i)) |-> $stable(tx_data_i))
    else begin
      $error("tx_data changed while tx_req was high");
      data_fails++;
    end

  arm_single: assert property (@(posedge clk_i) disable iff (!rst_in)
    arm_i |=> !arm_i)
    else begin
      $error("arm_o stayed high for more than one cycle");
      arm_fails++;
    end

  // No request and no ack means the transmitter sits in its idle state
  tx_idle_high: assert property (@(posedge clk_i) disable iff (!rst_in)
    (!tx_req_i && !tx_ack_i) |-> tx_i)
    else begin
      $error("tx_o was low while the transmitter was idle");
      idle_fails++;
    end

endmodule

bind sump_uart_top sump_uart_chk u_chk (
  .clk_i     (clk_i),
  .rst_in    (rst_in),
  .id_req_i  (id_req),
  .id_ack_i  (id_ack),
  .tx_req_i  (tx_req),
  .tx_ack_i  (tx_ack),
  .tx_data_i (tx_data),
  .arm_i     (arm_o),
  .tx_i      (tx_o)
);

// ==== testbench/sump_uart_monitor.sv ====
// ======================================================================
// Checker for the SUMP host link testbench
// Compares the register ports and the arm pulse count with the model
// on each check request, and rebuilds bytes from tx_o at mid-bit to
// match them against the queue of expected reply bytes
// ======================================================================

`timescale 1ns/1ps

module sump_uart_monitor (
  input  logic        clk_i,
  input  logic        rst_in,
  input  logic        tx_i,
  input  logic        arm_i,
  input  logic [31:0] trig_mask_i,
  input  logic [31:0] trig_value_i,
  input  logic [23:0] divider_i,
  input  logic [15:0] read_count_i,
  input  logic [15:0] delay_count_i,
  input  logic [7:0]  flags_i,
  input  logic [31:0] exp_trig_mask_i,
  input  logic [31:0] exp_trig_value_i,
  input  logic [23:0] exp_divider_i,
  input  logic [15:0] exp_read_count_i,
  input  logic [15:0] exp_delay_count_i,
  input  logic [7:0]  exp_flags_i,
  input  int          exp_arms_i,
  input  logic        check_i,
  input  logic        final_i,
  input  logic        push_i,
  input  logic [7:0]  push_byte_i,
  output int          pending_o,
  output int          errors_o
);

  import sump_pkg::*;

  logic [7:0] exp_q[$];
  int         arm_cnt;
  int         reg_errs;
  int         tx_errs;
  logic       busy;
  int         cyc;
  logic [7:0] rx_byte;
  logic [7:0] exp_byte;

  assign errors_o = reg_errs + tx_errs;

  function automatic int compare_field(input string name, input logic [31:0] got,
                                       input logic [31:0] exp_val);
    if (got !== exp_val) begin
      $display("MISMATCH at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp_val);
      return 1;
    end
    return 0;
  endfunction

  always @(posedge clk_i) begin : reg_check
    int n;
    n = 0;
    if (!rst_in) begin
      arm_cnt  <= 0;
      reg_errs <= 0;
    end else begin
      if (arm_i) begin
        arm_cnt <= arm_cnt + 1;
      end
      if (check_i || final_i) begin
        n += compare_field("trig_mask", trig_mask_i, exp_trig_mask_i);
        n += compare_field("trig_value", trig_value_i, exp_trig_value_i);
        n += compare_field("divider", 32'(divider_i), 32'(exp_divider_i));
        n += compare_field("read_count", 32'(read_count_i), 32'(exp_read_count_i));
        n += compare_field("delay_count", 32'(delay_count_i), 32'(exp_delay_count_i));
        n += compare_field("flags", 32'(flags_i), 32'(exp_flags_i));
        if (arm_cnt < exp_arms_i) begin
          $display("An arm pulse is missing, %0d seen but %0d expected", arm_cnt, exp_arms_i);
          n++;
        end else if (arm_cnt > exp_arms_i) begin
          $display("MISMATCH at %0t: %0d arm pulses seen, expected %0d",
                   $time, arm_cnt, exp_arms_i);
          n++;
        end
      end
      reg_errs <= reg_errs + n;
    end
  end

  // Start edge found one cycle late, so mid-bit k sits at k bits plus half
  always @(posedge clk_i) begin : tx_decode
    int n;
    n = 0;
    if (push_i) begin
      exp_q.push_back(push_byte_i);
    end
    if (!rst_in) begin
      busy    = 1'b0;
      tx_errs <= 0;
    end else if (!busy) begin
      if (!tx_i) begin
        busy = 1'b1;
        cyc  = 0;
      end
    end else begin
      cyc = cyc + 1;
      if (cyc % CLK_PER_BIT == CLK_PER_BIT / 2) begin
        if (cyc / CLK_PER_BIT == 0) begin
          if (tx_i) begin
            $display("Start bit on tx_o ended early at %0t", $time);
            busy = 1'b0;
            n++;
          end
        end else if (cyc / CLK_PER_BIT <= DATA_BITS) begin
          rx_byte = {tx_i, rx_byte[7:1]};
        end else begin
          busy = 1'b0;
          if (!tx_i) begin
            $display("Stop bit on tx_o missing at %0t", $time);
            n++;
          end
          if (exp_q.size() == 0) begin
            $display("MISMATCH at %0t: unexpected byte 0x%02h on tx_o", $time, rx_byte);
            n++;
          end else begin
            exp_byte = exp_q.pop_front();
            if (rx_byte !== exp_byte) begin
              $display("MISMATCH at %0t: tx byte 0x%02h, expected 0x%02h",
                       $time, rx_byte, exp_byte);
              n++;
            end
          end
        end
      end
    end
    if (final_i && exp_q.size() != 0) begin
      $display("%0d expected reply bytes were never transmitted", exp_q.size());
      n += exp_q.size();
    end
    if (rst_in) begin
      tx_errs <= tx_errs + n;
    end
    pending_o <= exp_q.size();
  end

endmodule

// ==== testbench/tb_sump_uart.sv ====
// ======================================================================
// Testbench for the SUMP host link
// Sends directed and then random SUMP commands over rx_i, keeps a
// model of the configuration registers, arm pulses and reply bytes,
// and lets the monitor compare the DUT against it after each command
// ======================================================================

`timescale 1ns/1ps

module tb_sump_uart;

  import sump_pkg::*;

  localparam int          NUM_CMDS     = 48;
  localparam int          NUM_DIRECTED = 11;
  localparam int          CLK_HALF     = 4;
  localparam logic [15:0] LFSR_SEED    = 16'd50;
  localparam int          WATCHDOG_CYC = NUM_CMDS * 60 * CLK_PER_BIT;

  // ASCII 1 A L S in send order
  localparam logic [7:0] ID_REPLY [4] = '{8'h31, 8'h41, 8'h4C, 8'h53};

  // Reply first, so the following long commands overlap with it
  localparam logic [7:0] DIRECTED_OPS [NUM_DIRECTED] = '{
    OP_ID, OP_TRIG_MASK, OP_TRIG_VALUE, OP_DIVIDER, OP_COUNTS, OP_FLAGS,
    OP_RUN, OP_META, 8'h90, 8'h33, OP_RESET
  };

  logic        clk;
  logic        rst_n;
  logic        rx;
  logic        tx;
  logic        arm;
  logic [31:0] trig_mask;
  logic [31:0] trig_value;
  logic [23:0] divider;
  logic [15:0] read_count;
  logic [15:0] delay_count;
  logic [7:0]  flags;

  logic [31:0] exp_trig_mask;
  logic [31:0] exp_trig_value;
  logic [23:0] exp_divider;
  logic [15:0] exp_read_count;
  logic [15:0] exp_delay_count;
  logic [7:0]  exp_flags;
  int          exp_arms;

  logic        check_req;
  logic        final_req;
  logic        push_req;
  logic [7:0]  push_byte;
  int          pending;
  int          mon_errors;
  int          tests_failed;
  int          assert_fails;
  logic [15:0] lfsr;
  logic [7:0]  op;

  sump_uart_top uut (
    .clk_i         (clk),
    .rst_in        (rst_n),
    .rx_i          (rx),
    .tx_o          (tx),
    .arm_o         (arm),
    .trig_mask_o   (trig_mask),
    .trig_value_o  (trig_value),
    .divider_o     (divider),
    .read_count_o  (read_count),
    .delay_count_o (delay_count),
    .flags_o       (flags)
  );

  sump_uart_monitor u_monitor (
    .clk_i             (clk),
    .rst_in            (rst_n),
    .tx_i              (tx),
    .arm_i             (arm),
    .trig_mask_i       (trig_mask),
    .trig_value_i      (trig_value),
    .divider_i         (divider),
    .read_count_i      (read_count),
    .delay_count_i     (delay_count),
    .flags_i           (flags),
    .exp_trig_mask_i   (exp_trig_mask),
    .exp_trig_value_i  (exp_trig_value),
    .exp_divider_i     (exp_divider),
    .exp_read_count_i  (exp_read_count),
    .exp_delay_count_i (exp_delay_count),
    .exp_flags_i       (exp_flags),
    .exp_arms_i        (exp_arms),
    .check_i           (check_req),
    .final_i           (final_req),
    .push_i            (push_req),
    .push_byte_i       (push_byte),
    .pending_o         (pending),
    .errors_o          (mon_errors)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("Timeout: the command sequence did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

  // 16-bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  function automatic logic [7:0] pick_opcode();
    logic [3:0] sel;
    logic [7:0] pick;
    sel = 4'(take_bits(4));
    case (sel)
      4'd0, 4'd1:   pick = OP_TRIG_MASK;
      4'd2, 4'd3:   pick = OP_TRIG_VALUE;
      4'd4:         pick = OP_DIVIDER;
      4'd5, 4'd6:   pick = OP_COUNTS;
      4'd7:         pick = OP_FLAGS;
      4'd8:         pick = OP_RESET;
      4'd9, 4'd10:  pick = OP_RUN;
      4'd11, 4'd12: pick = OP_ID;
      4'd13:        pick = OP_META;
      // Unknown short opcodes 0x03 to 0x42
      4'd14:        pick = 8'h03 + 8'(take_bits(6));
      // Unknown long opcodes 0x83 to 0xA2
      default:      pick = 8'h83 + 8'(take_bits(5));
    endcase
    return pick;
  endfunction

  task automatic drive_bit(input logic b);
    rx <= b;
    repeat (CLK_PER_BIT) @(posedge clk);
  endtask

  task automatic send_frame(input logic [7:0] b);
    int i;
    int gap;
    drive_bit(1'b0);
    for (i = 0; i < DATA_BITS; i++) begin
      drive_bit(b[i]);
    end
    drive_bit(1'b1);
    gap = 1 + int'(take_bits(2)) % 3;
    repeat (gap * CLK_PER_BIT) @(posedge clk);
  endtask

  task automatic push_reply();
    int i;
    for (i = 0; i < 4; i++) begin
      push_byte <= ID_REPLY[i];
      push_req  <= 1'b1;
      @(posedge clk);
    end
    push_req <= 1'b0;
  endtask

  // A new ID is only accepted once the previous reply is out
  task automatic wait_reply_idle();
    int i;
    for (i = 0; i < 60 * CLK_PER_BIT; i++) begin
      if (pending == 0) begin
        break;
      end
      @(posedge clk);
    end
  endtask

  task automatic update_model(input logic [7:0] cmd, input logic [31:0] arg);
    case (cmd)
      OP_RESET: begin
        exp_trig_mask   = '0;
        exp_trig_value  = '0;
        exp_divider     = '0;
        exp_read_count  = '0;
        exp_delay_count = '0;
        exp_flags       = '0;
      end
      OP_RUN:        exp_arms++;
      OP_TRIG_MASK:  exp_trig_mask = arg;
      OP_TRIG_VALUE: exp_trig_value = arg;
      OP_DIVIDER:    exp_divider = arg[23:0];
      OP_COUNTS: begin
        exp_read_count  = arg[15:0];
        exp_delay_count = arg[31:16];
      end
      OP_FLAGS:      exp_flags = arg[7:0];
      default: ;
    endcase
  endtask

  task automatic run_command(input int n, input logic [7:0] cmd);
    logic [31:0] arg;
    int          errs_before;
    int          i;
    arg         = take_bits(32);
    errs_before = mon_errors;
    if (cmd == OP_ID) begin
      wait_reply_idle();
      push_reply();
    end
    send_frame(cmd);
    // Long command, argument follows with its low byte first
    if (cmd[7]) begin
      for (i = 0; i < 4; i++) begin
        send_frame(arg[8*i +: 8]);
      end
    end
    update_model(cmd, arg);
    check_req <= 1'b1;
    @(posedge clk);
    check_req <= 1'b0;
    repeat (2) @(posedge clk);
    if (mon_errors == errs_before) begin
      $display("test %0d opcode 0x%02h arg 0x%08h: ok", n, cmd, arg);
    end else begin
      $display("test %0d opcode 0x%02h arg 0x%08h: error", n, cmd, arg);
      tests_failed++;
    end
  endtask

  initial begin
    rst_n           = 1'b0;
    rx              = 1'b1;
    check_req       = 1'b0;
    final_req       = 1'b0;
    push_req        = 1'b0;
    push_byte       = '0;
    exp_trig_mask   = '0;
    exp_trig_value  = '0;
    exp_divider     = '0;
    exp_read_count  = '0;
    exp_delay_count = '0;
    exp_flags       = '0;
    exp_arms        = 0;
    tests_failed    = 0;
    lfsr            = LFSR_SEED;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    for (int n = 0; n < NUM_CMDS; n++) begin
      op = (n < NUM_DIRECTED) ? DIRECTED_OPS[n] : pick_opcode();
      run_command(n, op);
    end

    wait_reply_idle();
    final_req <= 1'b1;
    @(posedge clk);
    final_req <= 1'b0;
    repeat (2) @(posedge clk);
    assert_fails = int'(uut.u_chk.fail_total);

    $display("Commands %0d, failed tests %0d, monitor errors %0d, assertion failures %0d",
             NUM_CMDS, tests_failed, mon_errors, assert_fails);
    if (tests_failed == 0 && mon_errors == 0 && assert_fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== sump_uart.f ====
source/sump_pkg.sv
source/tuart_rx.sv
source/tuart_tx.sv
source/sump_cmd_decoder.sv
source/sump_id_responder.sv
source/sump_uart_top.sv
testbench/sump_uart_chk.sv
testbench/sump_uart_monitor.sv
testbench/tb_sump_uart.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the SUMP host link testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f sump_uart.f \
  --top-module tb_sump_uart -Mdir "$build_dir" -o tb_sump_uart
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/tb_sump_uart" +verilator+error+limit+100 > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "Simulation run returned status $run_status"
  exit 1
fi

if grep -q "Simulation FAILED" "$log_file"; then
  exit 1
fi
if ! grep -q "Simulation PASSED" "$log_file"; then
  echo "No pass message found in $log_file"
  exit 1
fi
exit 0
